// ==== logic/regs_pkg.sv ====
/*
  Shared sizes, constants and channel types of the byte register block.
  The byte count must be a whole number of 32-bit chunks.
  Only the low ADDR_W address bits are decoded and higher bits alias.
  The read-only mask and the protection rule are fixed here.
*/
`default_nettype none

package regs_pkg;

  // Register array and bus geometry
  localparam int unsigned NUM_BYTES  = 12;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned STRB_W     = 4;
  localparam int unsigned NUM_CHUNKS = 3;
  // Five bits cover three chunks plus the out-of-range chunk 3
  localparam int unsigned ADDR_W     = 5;

  typedef logic [7:0]        byte_t;
  typedef logic [1:0]        chunk_idx_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Bytes 4 to 7 (all of chunk 1) and byte 9 can only be changed by logic
  localparam logic [NUM_BYTES-1:0] READ_ONLY = 12'h2F0;

  // Byte i comes out of reset as 8'hA0 plus i
  localparam byte_t [NUM_BYTES-1:0] RESET_VAL = {
    8'hAB, 8'hAA, 8'hA9, 8'hA8,
    8'hA7, 8'hA6, 8'hA5, 8'hA4,
    8'hA3, 8'hA2, 8'hA1, 8'hA0
  };

  // Protection rule, privileged accesses only
  localparam bit PRIV_ONLY   = 1'b1;
  localparam bit SECURE_ONLY = 1'b0;

  // Data pattern returned on a rejected read
  localparam logic [DATA_W-1:0] ERR_DATA = 32'hBA5E1E55;

  // Response codes as encoded on the AXI bus
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // Result of an address decode
  typedef struct packed {
    chunk_idx_t chunk;
    logic       allowed;
  } dec_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } r_chan_t;

  // Everything the bus master drives into the slave
  typedef struct packed {
    logic    aw_valid;
    addr_t   aw_addr;
    logic    [2:0] aw_prot;
    logic    w_valid;
    w_chan_t w;
    logic    b_ready;
    logic    ar_valid;
    addr_t   ar_addr;
    logic    [2:0] ar_prot;
    logic    r_ready;
  } axil_req_t;

  // Everything the slave drives back
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    ar_ready;
    logic    r_valid;
    r_chan_t r;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== logic/chunk_decode.sv ====
/*
  Address and protection decode for one address channel.
  The in-chunk byte offset is ignored, so any address in a chunk hits it.
  Pure combinational, no clock.
*/
`default_nettype none

module chunk_decode (
  input  regs_pkg::addr_t addr_i,
  input  logic [2:0]      prot_i,
  output regs_pkg::dec_t  dec_o
);

  import regs_pkg::*;

  // Full chunk field including the out-of-range value 3
  logic [2:0] chunk_full;
  logic       in_range;
  logic       prot_ok;

  // Bits 1:0 select the byte lane and are dropped here
  assign chunk_full = addr_i[ADDR_W-1:2];

  // Chunks at or above NUM_CHUNKS are not backed by registers
  assign in_range = (chunk_full < 3'(NUM_CHUNKS));

  // AxPROT bit 0 marks privileged, bit 1 set means non-secure in AXI
  // but the rule here only asks for the bit to be present when enabled
  assign prot_ok = (!PRIV_ONLY || prot_i[0]) &&
                   (!SECURE_ONLY || prot_i[1]);

  always_comb begin
    // Chunk index is passed on even when the access is rejected
    dec_o.chunk   = chunk_idx_t'(chunk_full[1:0]);
    dec_o.allowed = in_range && prot_ok;
  end

endmodule

`default_nettype wire

// ==== logic/write_execute.sv ====
/*
  Byte register array with bus write execution and logic load port.
  A bus write is held off while logic loads a writable byte it strobes.
  Rejected writes are taken at once with SLVERR and change nothing.
  The B entry goes to a buffer, which must be ready for a write to be taken.
*/
`default_nettype none

module write_execute (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        aw_valid_i,
  input  logic                                        w_valid_i,
  input  regs_pkg::w_chan_t                           w_i,
  input  regs_pkg::dec_t                              dec_i,
  input  logic                                        b_ready_i,
  output logic                                        aw_w_ready_o,
  output logic                                        b_valid_o,
  output regs_pkg::b_chan_t                           b_o,
  input  regs_pkg::byte_t [regs_pkg::NUM_BYTES-1:0]   reg_d_i,
  input  logic [regs_pkg::NUM_BYTES-1:0]              reg_load_i,
  output regs_pkg::byte_t [regs_pkg::NUM_BYTES-1:0]   reg_q_o
);

  import regs_pkg::*;

  byte_t [NUM_BYTES-1:0] reg_q;
  byte_t [NUM_BYTES-1:0] reg_next;

  // Per-byte view of the addressed chunk
  logic [NUM_BYTES-1:0]  in_chunk;
  logic [NUM_BYTES-1:0]  conflict;
  logic                  chunk_ro;
  logic                  stall;
  // An AW and W pair ready to go, independent of the B buffer
  logic                  write_req;
  logic                  accept;
  logic                  bus_write;

  // Mark the bytes of the addressed chunk and look for load conflicts
  always_comb begin
    chunk_ro = 1'b1;
    for (int unsigned b = 0; b < NUM_BYTES; b++) begin
      in_chunk[b] = (chunk_idx_t'(b / STRB_W) == dec_i.chunk);
      // A conflict needs a strobe, a load and a byte the bus may write
      conflict[b] = in_chunk[b] && w_i.strb[b % STRB_W] &&
                    reg_load_i[b] && !READ_ONLY[b];
      if (in_chunk[b] && !READ_ONLY[b]) begin
        chunk_ro = 1'b0;
      end
    end
  end

  // Rejected writes never stall since they touch no register
  assign stall     = dec_i.allowed && (|conflict);
  assign write_req = aw_valid_i && w_valid_i && !stall;
  assign accept    = write_req && b_ready_i;
  assign bus_write = accept && dec_i.allowed;

  // AW and W are taken together in the same cycle
  assign aw_w_ready_o = accept;
  // Valid into the B buffer does not wait on its ready
  assign b_valid_o    = write_req;

  always_comb begin
    if (!dec_i.allowed || chunk_ro) begin
      b_o.resp = SLVERR;
    end else begin
      b_o.resp = OKAY;
    end
  end

  // Next register state
  always_comb begin
    reg_next = reg_q;
    // Logic loads go to any byte, read-only bytes included
    for (int unsigned b = 0; b < NUM_BYTES; b++) begin
      if (reg_load_i[b]) begin
        reg_next[b] = reg_d_i[b];
      end
    end
    // The stall keeps bus writes off bytes being loaded, so order is free
    if (bus_write) begin
      for (int unsigned b = 0; b < NUM_BYTES; b++) begin
        if (in_chunk[b] && w_i.strb[b % STRB_W] && !READ_ONLY[b]) begin
          reg_next[b] = w_i.data[8*(b % STRB_W) +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_q <= RESET_VAL;
    end else begin
      reg_q <= reg_next;
    end
  end

  // Logic sees the stored value, one cycle after a load or write
  assign reg_q_o = reg_q;

endmodule

`default_nettype wire

// ==== logic/read_result.sv ====
/*
  Read data mux for the AR channel.
  Chunk byte 0 lands in data bits 7:0.
  A rejected read returns ERR_DATA with SLVERR.
  Combinational, the R buffer registers the result.
*/
`default_nettype none

module read_result (
  input  regs_pkg::dec_t                             dec_i,
  input  regs_pkg::byte_t [regs_pkg::NUM_BYTES-1:0]  reg_q_i,
  output regs_pkg::r_chan_t                          r_o
);

  import regs_pkg::*;

  logic [DATA_W-1:0] chunk_data;

  // Gather the four bytes of the addressed chunk
  always_comb begin
    chunk_data = '0;
    for (int unsigned b = 0; b < NUM_BYTES; b++) begin
      if (chunk_idx_t'(b / STRB_W) == dec_i.chunk) begin
        chunk_data[8*(b % STRB_W) +: 8] = reg_q_i[b];
      end
    end
  end

  always_comb begin
    if (dec_i.allowed) begin
      r_o.data = chunk_data;
      r_o.resp = OKAY;
    end else begin
      // Out-of-range chunks and failed protection land here
      r_o.data = ERR_DATA;
      r_o.resp = SLVERR;
    end
  end

endmodule

`default_nettype wire

// ==== logic/spill_buffer.sv ====
/*
  Two-entry FIFO between a valid/ready producer and consumer.
  Both ready_o and valid_o come from registers only, which cuts
  every combinational path between the two sides.
  Entries leave in the order they arrived.
*/
`default_nettype none

module spill_buffer #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Storage slots, addressed by the two pointers
  T           slot_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  // Number of occupied slots, 0 to 2
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Ready drops only when both slots hold an entry
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  // Oldest entry is always the one under the read pointer
  assign data_o  = slot_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Push and pop in the same cycle leave the count as it is
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/axil_regs_top.sv ====
/*
  AXI4-Lite style slave over 12 register bytes in three 32-bit chunks.
  Responses pass through two-entry buffers, so B and R arrive one cycle
  after acceptance at the earliest.
  AW and W must be presented together to be accepted.
*/
`default_nettype none

module axil_regs_top (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  regs_pkg::axil_req_t                        req_i,
  output regs_pkg::axil_rsp_t                        rsp_o,
  input  regs_pkg::byte_t [regs_pkg::NUM_BYTES-1:0]  reg_d_i,
  input  logic [regs_pkg::NUM_BYTES-1:0]             reg_load_i,
  output regs_pkg::byte_t [regs_pkg::NUM_BYTES-1:0]  reg_q_o
);

  import regs_pkg::*;

  dec_t    aw_dec;
  dec_t    ar_dec;
  logic    aw_w_ready;
  logic    b_valid;
  logic    b_ready;
  b_chan_t b_entry;
  r_chan_t r_entry;

  // Write address decode
  chunk_decode aw_decode (
    .addr_i ( req_i.aw_addr ),
    .prot_i ( req_i.aw_prot ),
    .dec_o  ( aw_dec        )
  );

  // Read address decode
  chunk_decode ar_decode (
    .addr_i ( req_i.ar_addr ),
    .prot_i ( req_i.ar_prot ),
    .dec_o  ( ar_dec        )
  );

  write_execute write_execute (
    .clk_i        ( clk_i          ),
    .reset_i      ( reset_i        ),
    .aw_valid_i   ( req_i.aw_valid ),
    .w_valid_i    ( req_i.w_valid  ),
    .w_i          ( req_i.w        ),
    .dec_i        ( aw_dec         ),
    .b_ready_i    ( b_ready        ),
    .aw_w_ready_o ( aw_w_ready     ),
    .b_valid_o    ( b_valid        ),
    .b_o          ( b_entry        ),
    .reg_d_i      ( reg_d_i        ),
    .reg_load_i   ( reg_load_i     ),
    .reg_q_o      ( reg_q_o        )
  );

  // Reads see the registered array in the accept cycle
  read_result read_result (
    .dec_i   ( ar_dec  ),
    .reg_q_i ( reg_q_o ),
    .r_o     ( r_entry )
  );

  assign rsp_o.aw_ready = aw_w_ready;
  assign rsp_o.w_ready  = aw_w_ready;

  spill_buffer #(
    .T ( b_chan_t )
  ) b_buffer (
    .clk_i   ( clk_i         ),
    .reset_i ( reset_i       ),
    .valid_i ( b_valid       ),
    .ready_o ( b_ready       ),
    .data_i  ( b_entry       ),
    .valid_o ( rsp_o.b_valid ),
    .ready_i ( req_i.b_ready ),
    .data_o  ( rsp_o.b       )
  );

  // AR is taken whenever the R buffer has room
  spill_buffer #(
    .T ( r_chan_t )
  ) r_buffer (
    .clk_i   ( clk_i          ),
    .reset_i ( reset_i        ),
    .valid_i ( req_i.ar_valid ),
    .ready_o ( rsp_o.ar_ready ),
    .data_i  ( r_entry        ),
    .valid_o ( rsp_o.r_valid  ),
    .ready_i ( req_i.r_ready  ),
    .data_o  ( rsp_o.r        )
  );

endmodule

`default_nettype wire

// ==== test/axil_regs_tb.sv ====
/*
  Testbench for the AXI4-Lite style byte register block.
  Inputs change 1 ns after the rising edge and outputs are sampled on the falling edge.
  Accesses are issued one at a time from a single driver process.
  Expected responses are queued at acceptance and checked in order.
*/
`default_nettype none

module axil_regs_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import regs_pkg::*;

  logic                  clk_i;
  logic                  reset_i;
  axil_req_t             req;
  axil_rsp_t             rsp;
  byte_t [NUM_BYTES-1:0] reg_d;
  logic [NUM_BYTES-1:0]  reg_load;
  byte_t [NUM_BYTES-1:0] reg_q;

  // Reference copy of the register bytes
  byte_t       model [NUM_BYTES];
  b_chan_t     exp_b_q [$];
  r_chan_t     exp_r_q [$];
  integer      seed;
  int unsigned timeout_cycles = 50;

  axil_regs_top dut0 (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .req_i      ( req      ),
    .rsp_o      ( rsp      ),
    .reg_d_i    ( reg_d    ),
    .reg_load_i ( reg_load ),
    .reg_q_o    ( reg_q    )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_with_fail(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_b(input b_chan_t got, input b_chan_t exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("error at %0t ns: B resp %0d, expected %0d",
                               $time, got.resp, exp.resp));
    end
  endtask

  task automatic check_r(input r_chan_t got, input r_chan_t exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("error at %0t ns: R data %h resp %0d, expected %h resp %0d",
                               $time, got.data, got.resp, exp.data, exp.resp));
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      stop_with_fail($sformatf("error at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_fail($sformatf("error at %0t ns: %s is %b, expected %b",
                               $time, what, got, exp));
    end
  endtask

  // Bytes 4 to 7 and byte 9 cannot be written from the bus
  function automatic logic ro_byte(input int idx);
    return ((idx >= 4) && (idx <= 7)) || (idx == 9);
  endfunction

  // Expected B response of a write, applied to the model as the DUT should
  function automatic b_chan_t exp_write(input addr_t addr, input logic [2:0] prot,
                                        input logic [3:0] strb, input logic [31:0] data);
    b_chan_t b;
    int      chunk;
    logic    all_ro;
    chunk  = int'(addr[4:2]);
    b.resp = SLVERR;
    if ((chunk < NUM_CHUNKS) && prot[0]) begin
      all_ro = 1'b1;
      for (int k = 0; k < STRB_W; k++) begin
        if (!ro_byte(chunk * STRB_W + k)) begin
          all_ro = 1'b0;
        end
      end
      if (!all_ro) begin
        b.resp = OKAY;
        for (int k = 0; k < STRB_W; k++) begin
          if (strb[k] && !ro_byte(chunk * STRB_W + k)) begin
            model[chunk * STRB_W + k] = data[8*k +: 8];
          end
        end
      end
    end
    return b;
  endfunction

  function automatic r_chan_t exp_read(input addr_t addr, input logic [2:0] prot);
    r_chan_t r;
    int      chunk;
    chunk  = int'(addr[4:2]);
    r.data = 32'hBA5E1E55;
    r.resp = SLVERR;
    if ((chunk < NUM_CHUNKS) && prot[0]) begin
      r.resp = OKAY;
      for (int k = 0; k < STRB_W; k++) begin
        r.data[8*k +: 8] = model[chunk * STRB_W + k];
      end
    end
    return r;
  endfunction

  task automatic start_write(input addr_t addr, input logic [2:0] prot,
                             input logic [3:0] strb, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    req.aw_valid = 1'b1;
    req.aw_addr  = addr;
    req.aw_prot  = prot;
    req.w_valid  = 1'b1;
    req.w.strb   = strb;
    req.w.data   = data;
  endtask

  // Waits for AW and W to be taken, then queues the expected B entry
  task automatic finish_write();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!(rsp.aw_ready && rsp.w_ready)) begin
      cycles++;
      if (cycles > timeout_cycles) begin
        stop_with_fail("timeout while waiting for aw_ready and w_ready");
      end
      @(negedge clk_i);
    end
    exp_b_q.push_back(exp_write(req.aw_addr, req.aw_prot, req.w.strb, req.w.data));
    @(posedge clk_i);
    #1;
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
  endtask

  task automatic start_read(input addr_t addr, input logic [2:0] prot);
    @(posedge clk_i);
    #1;
    req.ar_valid = 1'b1;
    req.ar_addr  = addr;
    req.ar_prot  = prot;
  endtask

  task automatic finish_read();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!rsp.ar_ready) begin
      cycles++;
      if (cycles > timeout_cycles) begin
        stop_with_fail("timeout while waiting for ar_ready");
      end
      @(negedge clk_i);
    end
    // Read data is the register content in the accept cycle
    exp_r_q.push_back(exp_read(req.ar_addr, req.ar_prot));
    @(posedge clk_i);
    #1;
    req.ar_valid = 1'b0;
  endtask

  task automatic write_bus(input addr_t addr, input logic [2:0] prot,
                           input logic [3:0] strb, input logic [31:0] data);
    start_write(addr, prot, strb, data);
    finish_write();
  endtask

  task automatic read_bus(input addr_t addr, input logic [2:0] prot);
    start_read(addr, prot);
    finish_read();
  endtask

  // Ready must stay low while a request is waiting
  task automatic expect_held_off(input bit is_write, input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      if (is_write) begin
        check_flag(rsp.aw_ready, 1'b0, "aw_ready while write is held off");
        check_flag(rsp.w_ready, 1'b0, "w_ready while write is held off");
      end else begin
        check_flag(rsp.ar_ready, 1'b0, "ar_ready while R buffer is full");
      end
    end
  endtask

  task automatic load_byte(input int idx, input byte_t val);
    @(posedge clk_i);
    #1;
    reg_load[idx] = 1'b1;
    reg_d[idx]    = val;
    model[idx]    = val;
  endtask

  task automatic release_loads();
    @(posedge clk_i);
    #1;
    reg_load = '0;
  endtask

  function automatic addr_t chunk_addr(input int chunk);
    return addr_t'({chunk[2:0], 2'($random(seed))});
  endfunction

  // Compares every response handed over on B and R with the queued expectation
  initial begin
    b_chan_t exp_b;
    r_chan_t exp_r;
    forever begin
      @(negedge clk_i);
      if (!reset_i && rsp.b_valid && req.b_ready) begin
        if (exp_b_q.size() == 0) begin
          stop_with_fail("a B response arrived with no write outstanding");
        end
        exp_b = exp_b_q.pop_front();
        check_b(rsp.b, exp_b);
      end
      if (!reset_i && rsp.r_valid && req.r_ready) begin
        if (exp_r_q.size() == 0) begin
          stop_with_fail("an R response arrived with no read outstanding");
        end
        exp_r = exp_r_q.pop_front();
        check_r(rsp.r, exp_r);
      end
    end
  end

  initial begin
    int unsigned cycles;
    seed        = 2363;
    req         = '0;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    reg_d       = '0;
    reg_load    = '0;
    reset_i     = 1'b1;
    for (int i = 0; i < NUM_BYTES; i++) begin
      model[i] = 8'hA0 + byte_t'(i);
    end
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Idle outputs and reset contents
    @(negedge clk_i);
    check_flag(rsp.b_valid, 1'b0, "b_valid after reset");
    check_flag(rsp.r_valid, 1'b0, "r_valid after reset");
    check_flag(rsp.ar_ready, 1'b1, "ar_ready after reset");
    for (int i = 0; i < NUM_BYTES; i++) begin
      check_byte(reg_q[i], model[i], "reg_q_o byte after reset");
    end
    for (int c = 0; c < NUM_CHUNKS; c++) begin
      read_bus(chunk_addr(c), 3'b001);
    end

    // Random strobed writes to the two writable chunks, each read back
    repeat (8) begin
      int c;
      c = ($random(seed) & 1) ? 2 : 0;
      write_bus(chunk_addr(c), 3'b001, 4'($random(seed)), $random(seed));
      read_bus(chunk_addr(c), 3'b001);
    end

    // Chunk 1 is fully read-only, chunk 2 keeps byte 9
    write_bus(chunk_addr(1), 3'b001, 4'hF, 32'h1234_5678);
    read_bus(chunk_addr(1), 3'b001);
    write_bus(chunk_addr(2), 3'b001, 4'hF, 32'hC0DE_F00D);
    read_bus(chunk_addr(2), 3'b001);

    // Out-of-range chunk and missing privilege
    write_bus(chunk_addr(3), 3'b001, 4'hF, 32'hDEAD_BEEF);
    read_bus(chunk_addr(3), 3'b001);
    write_bus(chunk_addr(0), 3'b010, 4'hF, 32'hDEAD_BEEF);
    read_bus(chunk_addr(0), 3'b110);
    read_bus(chunk_addr(0), 3'b001);

    // Logic load on byte 1 stalls a bus write that strobes it
    load_byte(1, 8'h5C);
    @(posedge clk_i);
    @(negedge clk_i);
    check_byte(reg_q[1], 8'h5C, "reg_q_o byte 1 after load");
    start_write(chunk_addr(0), 3'b001, 4'b0011, 32'h0000_E7D4);
    expect_held_off(1'b1, 4);
    release_loads();
    finish_write();
    read_bus(chunk_addr(0), 3'b001);

    // Read-only byte 5 still takes a logic load
    load_byte(5, 8'h3E);
    release_loads();
    @(negedge clk_i);
    check_byte(reg_q[5], 8'h3E, "reg_q_o byte 5 after load");
    read_bus(chunk_addr(1), 3'b001);

    // Back-pressure fills both buffers before ready drops
    @(posedge clk_i);
    #1;
    req.b_ready = 1'b0;
    req.r_ready = 1'b0;
    read_bus(chunk_addr(0), 3'b001);
    read_bus(chunk_addr(2), 3'b001);
    start_read(chunk_addr(1), 3'b001);
    expect_held_off(1'b0, 3);
    write_bus(chunk_addr(0), 3'b001, 4'($random(seed)), $random(seed));
    write_bus(chunk_addr(2), 3'b001, 4'($random(seed)), $random(seed));
    start_write(chunk_addr(1), 3'b001, 4'hF, $random(seed));
    expect_held_off(1'b1, 3);
    // R drains first while the full B buffer keeps the write held off
    @(posedge clk_i);
    #1;
    req.r_ready = 1'b1;
    finish_read();
    @(posedge clk_i);
    #1;
    req.b_ready = 1'b1;
    finish_write();
    read_bus(chunk_addr(0), 3'b001);
    read_bus(chunk_addr(2), 3'b001);

    // Let every queued response drain
    cycles = 0;
    while ((exp_b_q.size() != 0) || (exp_r_q.size() != 0)) begin
      cycles++;
      if (cycles > timeout_cycles) begin
        stop_with_fail("timeout while waiting for outstanding responses");
      end
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/regs_pkg.sv
logic/chunk_decode.sv
logic/write_execute.sv
logic/read_result.sv
logic/spill_buffer.sv
logic/axil_regs_top.sv
test/axil_regs_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; a $fatal gives a nonzero exit status
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal --top-module axil_regs_tb \
       -f build.f -o axil_regs_sim \
  && ./obj_dir/axil_regs_sim \
  || exit 1
